// File: logic/ntm_inverter_params.svh
////////////////////////////////////////////////////////////////////////////
// Default sizes of the modular inverter
// Moduli must be odd and at least 3 and fit in NTM_DATA_SIZE bits
////////////////////////////////////////////////////////////////////////////

`ifndef NTM_INVERTER_PARAMS_SVH
`define NTM_INVERTER_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// Width of operands, moduli and results
`define NTM_DATA_SIZE 16

////////////////////////////////////////////////////////////////////////////
// Vector control
////////////////////////////////////////////////////////////////////////////

// Width of the element count and index (vectors up to 255 elements)
`define NTM_SIZE_WIDTH 8

`endif

// File: logic/ntm_inverter_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the modular inverter, sized by the params header
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ntm_inverter_params.svh"

package ntm_inverter_pkg;

  // Operand, modulus and result words
  typedef logic [`NTM_DATA_SIZE-1:0] data_word_t;

  // Element count and element index
  typedef logic [`NTM_SIZE_WIDTH-1:0] vector_size_t;

  // One element as it enters the vector inverter
  typedef struct packed {
    data_word_t modulus;
    data_word_t data;
  } inverter_operand_t;

  // Scalar FSM
  typedef enum logic [1:0] {
    SCALAR_IDLE,
    SCALAR_REDUCE,
    SCALAR_FINISH
  } scalar_state_t;

  // Vector FSM
  typedef enum logic [1:0] {
    VECTOR_STARTER,
    VECTOR_INPUT,
    VECTOR_ENDER
  } vector_state_t;

endpackage

`default_nettype wire

// File: logic/ntm_scalar_inverter.sv
////////////////////////////////////////////////////////////////////////////
// Binary extended Euclid inverse. Odd modulus of at least 3 required
// Result is zero when the data shares a factor with the modulus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_inverter_params.svh"

module ntm_scalar_inverter #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  wire                         CLK,
  input  wire                         RST,

  // Control
  input  wire                         START,
  output logic                        READY,

  // Data
  input  ntm_inverter_pkg::data_word_t MODULO_IN,
  input  ntm_inverter_pkg::data_word_t DATA_IN,
  output ntm_inverter_pkg::data_word_t DATA_OUT
);

  import ntm_inverter_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  scalar_state_t state;

  // Working pair and their coefficients
  // Invariant is x1*data = u and x2*data = v modulo the modulus
  logic [DATA_SIZE-1:0] u_reg;
  logic [DATA_SIZE-1:0] v_reg;
  logic [DATA_SIZE-1:0] x1_reg;
  logic [DATA_SIZE-1:0] x2_reg;
  logic [DATA_SIZE-1:0] modulus_reg;

  // Termination flags
  logic u_is_one;
  logic v_is_one;
  logic no_inverse;
  logic reduce_done;

  logic [DATA_SIZE-1:0] result_word;

  ////////////////////////////////////////////////////////////////////////////
  // Modular helpers
  ////////////////////////////////////////////////////////////////////////////

  // x/2 mod m for odd m and x below m
  function automatic logic [DATA_SIZE-1:0] half_mod(
    input logic [DATA_SIZE-1:0] x,
    input logic [DATA_SIZE-1:0] m
  );
    logic [DATA_SIZE:0] sum;
    // Odd x gets the modulus added so the sum is even
    if (x[0]) begin
      sum = {1'b0, x} + {1'b0, m};
    end else begin
      sum = {1'b0, x};
    end
    return sum[DATA_SIZE:1];
  endfunction

  // (a - b) mod m for a and b below m
  function automatic logic [DATA_SIZE-1:0] sub_mod(
    input logic [DATA_SIZE-1:0] a,
    input logic [DATA_SIZE-1:0] b,
    input logic [DATA_SIZE-1:0] m
  );
    logic [DATA_SIZE-1:0] diff;
    diff = a - b;
    // Wraps back into range when b is larger
    if (a < b) begin
      diff = diff + m;
    end
    return diff;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Termination
  ////////////////////////////////////////////////////////////////////////////

  assign u_is_one    = (u_reg == DATA_SIZE'(1));
  assign v_is_one    = (v_reg == DATA_SIZE'(1));
  // A zero means u and v met at the gcd which is not 1
  assign no_inverse  = (u_reg == '0) || (v_reg == '0);
  assign reduce_done = u_is_one || v_is_one || no_inverse;

  // Coefficient belonging to the 1
  always_comb begin
    if (u_is_one) begin
      result_word = x1_reg;
    end else if (v_is_one) begin
      result_word = x2_reg;
    end else begin
      result_word = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= SCALAR_IDLE;
      READY    <= 1'b0;
      DATA_OUT <= '0;
    end else begin
      // Single cycle pulse
      READY <= 1'b0;
      case (state)
        SCALAR_IDLE: begin
          if (START) begin
            state <= SCALAR_REDUCE;
          end
        end
        SCALAR_REDUCE: begin
          // One reduction step per cycle until a flag rises
          if (reduce_done) begin
            state <= SCALAR_FINISH;
          end
        end
        SCALAR_FINISH: begin
          DATA_OUT <= result_word;
          READY    <= 1'b1;
          state    <= SCALAR_IDLE;
        end
        default: begin
          state <= SCALAR_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reduction datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == SCALAR_IDLE && START) begin
      // Load data and modulus with unit coefficients
      u_reg       <= DATA_IN;
      v_reg       <= MODULO_IN;
      x1_reg      <= DATA_SIZE'(1);
      x2_reg      <= '0;
      modulus_reg <= MODULO_IN;
    end else if (state == SCALAR_REDUCE && !reduce_done) begin
      if (!u_reg[0]) begin
        // Even u
        u_reg  <= u_reg >> 1;
        x1_reg <= half_mod(x1_reg, modulus_reg);
      end else if (!v_reg[0]) begin
        // Even v
        v_reg  <= v_reg >> 1;
        x2_reg <= half_mod(x2_reg, modulus_reg);
      end else if (u_reg >= v_reg) begin
        // Both odd so the difference is even and halves in the same step
        u_reg  <= (u_reg - v_reg) >> 1;
        x1_reg <= half_mod(sub_mod(x1_reg, x2_reg, modulus_reg), modulus_reg);
      end else begin
        v_reg  <= (v_reg - u_reg) >> 1;
        x2_reg <= half_mod(sub_mod(x2_reg, x1_reg, modulus_reg), modulus_reg);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // New START only while idle
  start_when_idle: assert property (
    @(posedge CLK) disable iff (RST) START |-> (state == SCALAR_IDLE)
  ) else $error("scalar START while a reduction is running");

  // Halving relies on an odd modulus
  modulus_odd_at_start: assert property (
    @(posedge CLK) disable iff (RST) START |-> MODULO_IN[0]
  ) else $error("even modulus at scalar START");

endmodule

`default_nettype wire

// File: logic/ntm_vector_inverter.sv
////////////////////////////////////////////////////////////////////////////
// Vector inverter top. One element in flight and no back-pressure
// Send the next element only after DATA_OUT_ENABLE of the previous one
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_inverter_params.svh"

module ntm_vector_inverter #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  wire                                CLK,
  input  wire                                RST,

  // Control
  input  wire                                START,
  output logic                               READY,
  input  ntm_inverter_pkg::vector_size_t      SIZE_IN,

  // Element stream in
  input  wire                                DATA_IN_ENABLE,
  input  ntm_inverter_pkg::inverter_operand_t OPERAND_IN,

  // Result stream out
  output logic                               DATA_OUT_ENABLE,
  output ntm_inverter_pkg::data_word_t        DATA_OUT
);

  import ntm_inverter_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  vector_state_t state;

  // Vector bookkeeping
  vector_size_t size_reg;
  vector_size_t index_reg;
  vector_size_t last_index;

  // Scalar unit handshake
  logic              start_scalar;
  logic              ready_scalar;
  inverter_operand_t operand_reg;
  data_word_t        data_out_scalar;

  // Element accepted this cycle
  logic take_operand;

  assign last_index   = size_reg - vector_size_t'(1);
  assign take_operand = (state == VECTOR_INPUT) && DATA_IN_ENABLE;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= VECTOR_STARTER;
      size_reg        <= '0;
      index_reg       <= '0;
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Pulses default low
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        VECTOR_STARTER: begin
          if (START) begin
            size_reg  <= SIZE_IN;
            index_reg <= '0;
            state     <= VECTOR_INPUT;
          end
        end
        VECTOR_INPUT: begin
          // Operand lands in its register on the same edge
          if (DATA_IN_ENABLE) begin
            start_scalar <= 1'b1;
            state        <= VECTOR_ENDER;
          end
        end
        VECTOR_ENDER: begin
          if (ready_scalar) begin
            DATA_OUT        <= data_out_scalar;
            DATA_OUT_ENABLE <= 1'b1;
            if (index_reg == last_index) begin
              // Last element closes the vector
              READY <= 1'b1;
              state <= VECTOR_STARTER;
            end else begin
              index_reg <= index_reg + vector_size_t'(1);
              state     <= VECTOR_INPUT;
            end
          end
        end
        default: begin
          state <= VECTOR_STARTER;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand register
  ////////////////////////////////////////////////////////////////////////////

  // Held stable for the whole scalar run
  always_ff @(posedge CLK) begin
    if (take_operand) begin
      operand_reg <= OPERAND_IN;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scalar unit
  ////////////////////////////////////////////////////////////////////////////

  ntm_scalar_inverter #(
    .DATA_SIZE (DATA_SIZE)
  ) scalar_inverter (
    .CLK       (CLK),
    .RST       (RST),
    .START     (start_scalar),
    .READY     (ready_scalar),
    .MODULO_IN (operand_reg.modulus),
    .DATA_IN   (operand_reg.data),
    .DATA_OUT  (data_out_scalar)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Scalar result only while one is awaited
  scalar_ready_in_ender: assert property (
    @(posedge CLK) disable iff (RST) ready_scalar |-> (state == VECTOR_ENDER)
  ) else $error("scalar READY outside the ender state");

  // An empty vector would never finish
  size_nonzero: assert property (
    @(posedge CLK) disable iff (RST)
      (START && state == VECTOR_STARTER) |=> (size_reg != '0)
  ) else $error("zero SIZE_IN latched at START");

endmodule

`default_nettype wire

// File: verification/ntm_inverter_model.svh
////////////////////////////////////////////////////////////////////////////
// Reference inverse and checking, included inside the testbench module
////////////////////////////////////////////////////////////////////////////

`ifndef NTM_INVERTER_MODEL_SVH
`define NTM_INVERTER_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Counters
////////////////////////////////////////////////////////////////////////////

int error_count = 0;
int check_count = 0;
int tests_run = 0;
int tests_failed = 0;

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

// Brute force search for x with data*x mod m equal to 1
// Zero when no such x exists
function automatic int unsigned model_inverse(
  input int unsigned data,
  input int unsigned m
);
  longint unsigned prod;
  for (int unsigned x = 1; x < m; x++) begin
    prod = longint'(data) * longint'(x);
    if ((prod % m) == 1) begin
      return x;
    end
  end
  return 0;
endfunction

// Trial division, used to pick prime moduli
function automatic bit is_prime(input int unsigned n);
  if (n < 2) begin
    return 1'b0;
  end
  for (int unsigned d = 2; d * d <= n; d++) begin
    if ((n % d) == 0) begin
      return 1'b0;
    end
  end
  return 1'b1;
endfunction

////////////////////////////////////////////////////////////////////////////
// Comparison
////////////////////////////////////////////////////////////////////////////

task automatic check_value(
  input string       name,
  input int unsigned expected,
  input int unsigned actual
);
  check_count++;
  if (expected !== actual) begin
    error_count++;
    $display("MISMATCH at %0t ns: %s expected %0d actual %0d",
             $time, name, expected, actual);
  end
endtask

`endif

// File: verification/ntm_vector_inverter_tb.sv
////////////////////////////////////////////////////////////////////////////
// Random vectors with odd moduli only, one element in flight at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ntm_inverter_params.svh"

module ntm_vector_inverter_tb;

  import ntm_inverter_pkg::*;

  // Elements over all tests, sizes the watchdog
  localparam int MAX_ELEMENTS = 8 * 16 + 16 + 8 + 4 + 8;
  localparam int ELEMENT_CYCLES = 2 * `NTM_DATA_SIZE + 8;
  localparam longint WATCHDOG_NS = (MAX_ELEMENTS * ELEMENT_CYCLES + 2000) * 20;

  logic CLK = 1'b0;
  logic RST;
  logic START;
  vector_size_t SIZE_IN;
  logic DATA_IN_ENABLE;
  inverter_operand_t OPERAND_IN;
  logic READY;
  logic DATA_OUT_ENABLE;
  data_word_t DATA_OUT;

  `include "ntm_inverter_model.svh"

  // Results still owed by the DUT
  int unsigned expected_queue[$];
  // Bookkeeping for the running vector
  int vec_size;
  int out_count;
  int ready_count;

  int small_primes[14] = '{3, 5, 7, 11, 13, 17, 19, 23, 29, 31, 37, 41, 43, 47};

  always #10 CLK = ~CLK;

  ntm_vector_inverter ntm_vector_inverter_i (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .READY           (READY),
    .SIZE_IN         (SIZE_IN),
    .DATA_IN_ENABLE  (DATA_IN_ENABLE),
    .OPERAND_IN      (OPERAND_IN),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (DATA_OUT_ENABLE === 1'b1) begin
      out_count++;
      if (expected_queue.size() == 0) begin
        error_count++;
        $display("Unexpected result at %0t ns with no element pending", $time);
      end else begin
        check_value("DATA_OUT", expected_queue.pop_front(), DATA_OUT);
      end
    end
    if (READY === 1'b1) begin
      ready_count++;
      if (DATA_OUT_ENABLE !== 1'b1) begin
        error_count++;
        $display("READY rose at %0t ns without a result", $time);
      end
      // End of vector only on the last element
      check_value("READY element index", vec_size, out_count);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    RST <= 1'b1;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
  endtask

  task automatic start_vector(input int size);
    vec_size = size;
    out_count = 0;
    ready_count = 0;
    @(posedge CLK);
    START <= 1'b1;
    SIZE_IN <= vector_size_t'(size);
    @(posedge CLK);
    START <= 1'b0;
  endtask

  // Strobe one element and wait for its result
  task automatic send_element(input int unsigned data, input int unsigned m);
    inverter_operand_t op;
    op.modulus = data_word_t'(m);
    op.data = data_word_t'(data);
    expected_queue.push_back(model_inverse(data, m));
    DATA_IN_ENABLE <= 1'b1;
    OPERAND_IN <= op;
    @(posedge CLK);
    DATA_IN_ENABLE <= 1'b0;
    do @(posedge CLK); while (DATA_OUT_ENABLE !== 1'b1);
  endtask

  // Pulse counts after the last result
  task automatic finish_vector();
    @(posedge CLK);
    check_value("DATA_OUT_ENABLE count", vec_size, out_count);
    check_value("READY count", 1, ready_count);
  endtask

  function automatic int unsigned random_prime();
    int unsigned m;
    do m = ($urandom % 32767) * 2 + 3; while (!is_prime(m));
    return m;
  endfunction

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int errs;
    int size;
    int unsigned m;
    int unsigned p;
    int unsigned q;
    int unsigned d;
    int unsigned composite_moduli[8];
    void'($urandom(32'hd6ea_a0ea));
    START <= 1'b0;
    SIZE_IN <= '0;
    DATA_IN_ENABLE <= 1'b0;
    OPERAND_IN <= '0;
    apply_reset();

    // Prime moduli, random sizes
    errs = error_count;
    for (int v = 0; v < 8; v++) begin
      size = 1 + ($urandom % 16);
      start_vector(size);
      for (int i = 0; i < size; i++) begin
        m = random_prime();
        send_element(1 + ($urandom % (m - 1)), m);
      end
      finish_vector();
    end
    report_test("prime moduli", errs);

    // Composite moduli, shared factor then coprime data
    errs = error_count;
    for (int v = 0; v < 2; v++) begin
      start_vector(8);
      for (int i = 0; i < 8; i++) begin
        if (v == 0) begin
          p = small_primes[$urandom % 14];
          q = small_primes[$urandom % 14];
          m = p * q;
          composite_moduli[i] = m;
          check_value("model shared factor", 0, model_inverse(p, m));
          send_element(p * (1 + ($urandom % (q - 1))), m);
        end else begin
          // Same moduli again, data redrawn until coprime
          m = composite_moduli[i];
          do begin
            d = 1 + ($urandom % (m - 1));
          end while (model_inverse(d, m) == 0);
          send_element(d, m);
        end
      end
      finish_vector();
    end
    report_test("composite moduli", errs);

    // Data 1 and m-1 are their own inverses
    errs = error_count;
    start_vector(8);
    for (int i = 0; i < 4; i++) begin
      m = random_prime();
      check_value("model one", 1, model_inverse(1, m));
      check_value("model m-1", m - 1, model_inverse(m - 1, m));
      send_element(1, m);
      send_element(m - 1, m);
    end
    finish_vector();
    report_test("edge operands", errs);

    // Reset with the second element still in flight
    errs = error_count;
    start_vector(4);
    send_element(2, 7);
    DATA_IN_ENABLE <= 1'b1;
    OPERAND_IN <= {data_word_t'(11), data_word_t'(3)};
    @(posedge CLK);
    DATA_IN_ENABLE <= 1'b0;
    repeat (3) @(posedge CLK);
    apply_reset();
    repeat (12) begin
      @(posedge CLK);
      check_value("READY after reset", 0, READY);
      check_value("DATA_OUT_ENABLE after reset", 0, DATA_OUT_ENABLE);
      check_value("DATA_OUT after reset", 0, DATA_OUT);
    end
    start_vector(8);
    for (int i = 0; i < 8; i++) begin
      m = random_prime();
      send_element(1 + ($urandom % (m - 1)), m);
    end
    finish_vector();
    report_test("reset mid vector", errs);

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the DUT stopped producing results before the tests ended");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
+incdir+verification
logic/ntm_inverter_pkg.sv
logic/ntm_scalar_inverter.sv
logic/ntm_vector_inverter.sv
verification/ntm_vector_inverter_tb.sv

// File: run.sh
#!/bin/sh
# Builds the vector inverter testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f src.f \
  --top-module ntm_vector_inverter_tb

output=$(./obj_dir/Vntm_vector_inverter_tb)
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
